//--- include/decode_settings.svh
`ifndef DECODE_SETTINGS_SVH
`define DECODE_SETTINGS_SVH

// Data and address width.
`define XLEN 32

// Architectural register count.
`define REG_COUNT 32

// Width of a register name field.
`define REG_NAME_W 5

`endif

//--- rtl/decodePkg.sv
package decodePkg;

    // Decoded operations; anything not recognised becomes NOP.
    typedef enum logic [5:0] {
        NOP,
        LUI,
        AUIPC,
        JAL,
        JALR,
        BEQ,
        BNE,
        BLT,
        BGE,
        BLTU,
        BGEU,
        LB,
        LH,
        LW,
        LBU,
        LHU,
        SB,
        SH,
        SW,
        ADDI,
        SLTI,
        SLTIU,
        XORI,
        ORI,
        ANDI,
        SLLI,
        SRLI,
        SRAI,
        ADD,
        SUB,
        SLL,
        SLT,
        SLTU,
        XOR,
        SRL,
        SRA,
        OR,
        AND
    } opT;

    // RV32I major opcodes.
    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_OPIMM  = 7'b0010011,
        OPC_OP     = 7'b0110011
    } opcodeT;

    // Handshake states of the input and output machines.
    typedef enum logic [1:0] {
        ST_IDLE    = 2'd0,
        ST_ACTIVE  = 2'd1,
        ST_RELEASE = 2'd2
    } issueStateT;

endpackage

//--- rtl/opDecoder.sv
module opDecoder (
    input  logic [31:0]    inst,
    output decodePkg::opT  op
);
    import decodePkg::*;

    opcodeT     opcode;
    logic [2:0] funct3;
    logic       alt;

    assign opcode = opcodeT'(inst[6:0]);
    assign funct3 = inst[14:12];
    // Bit 30 picks SUB/SRA/SRAI.
    assign alt    = inst[30];

    always_comb begin
        op = NOP;
        case (opcode)
            OPC_LUI:   op = LUI;
            OPC_AUIPC: op = AUIPC;
            OPC_JAL:   op = JAL;
            OPC_JALR: begin
                if (funct3 == 3'b000) begin
                    op = JALR;
                end
            end
            OPC_BRANCH: begin
                case (funct3)
                    3'b000:  op = BEQ;
                    3'b001:  op = BNE;
                    3'b100:  op = BLT;
                    3'b101:  op = BGE;
                    3'b110:  op = BLTU;
                    3'b111:  op = BGEU;
                    default: op = NOP;
                endcase
            end
            OPC_LOAD: begin
                case (funct3)
                    3'b000:  op = LB;
                    3'b001:  op = LH;
                    3'b010:  op = LW;
                    3'b100:  op = LBU;
                    3'b101:  op = LHU;
                    default: op = NOP;
                endcase
            end
            OPC_STORE: begin
                case (funct3)
                    3'b000:  op = SB;
                    3'b001:  op = SH;
                    3'b010:  op = SW;
                    default: op = NOP;
                endcase
            end
            OPC_OPIMM: begin
                // Bit 30 only matters for the shifts here.
                case (funct3)
                    3'b000: op = ADDI;
                    3'b010: op = SLTI;
                    3'b011: op = SLTIU;
                    3'b100: op = XORI;
                    3'b110: op = ORI;
                    3'b111: op = ANDI;
                    3'b001: begin
                        op = alt ? NOP : SLLI;
                    end
                    3'b101: begin
                        op = alt ? SRAI : SRLI;
                    end
                    default: op = NOP;
                endcase
            end
            OPC_OP: begin
                case ({alt, funct3})
                    4'b0000: op = ADD;
                    4'b1000: op = SUB;
                    4'b0001: op = SLL;
                    4'b0010: op = SLT;
                    4'b0011: op = SLTU;
                    4'b0100: op = XOR;
                    4'b0101: op = SRL;
                    4'b1101: op = SRA;
                    4'b0110: op = OR;
                    4'b0111: op = AND;
                    default: op = NOP;
                endcase
            end
            default: op = NOP;
        endcase
    end

endmodule

//--- rtl/immGenerator.sv
`include "decode_settings.svh"

module immGenerator (
    input  logic [31:0]       inst,
    output logic [`XLEN-1:0]  imm
);
    import decodePkg::*;

    opcodeT opcode;

    assign opcode = opcodeT'(inst[6:0]);

    always_comb begin
        case (opcode)
            // U format with the low bits cleared.
            OPC_LUI,
            OPC_AUIPC: begin
                imm = {inst[31:12], 12'b0};
            end
            OPC_JAL: begin
                imm = {{(`XLEN-20){inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            end
            OPC_BRANCH: begin
                imm = {{(`XLEN-12){inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            end
            OPC_JALR,
            OPC_LOAD,
            OPC_OPIMM: begin
                imm = {{(`XLEN-12){inst[31]}}, inst[31:20]};
            end
            OPC_STORE: begin
                imm = {{(`XLEN-12){inst[31]}}, inst[31:25], inst[11:7]};
            end
            // R format has no immediate.
            default: begin
                imm = '0;
            end
        endcase
    end

endmodule

//--- rtl/regFile.sv
`include "decode_settings.svh"

module regFile (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [`REG_NAME_W-1:0] rs1,
    input  logic [`REG_NAME_W-1:0] rs2,
    output logic [`XLEN-1:0]       rs1Val,
    output logic [`XLEN-1:0]       rs2Val,
    input  logic                   wbEn,
    input  logic [`REG_NAME_W-1:0] wbRd,
    input  logic [`XLEN-1:0]       wbData
);

    logic [`XLEN-1:0] regs [`REG_COUNT];
    logic             wbActive;

    // Writes to x0 are dropped.
    assign wbActive = wbEn && (wbRd != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wbActive) begin
            regs[wbRd] <= wbData;
        end
    end

    // Same-cycle write is forwarded.
    always_comb begin
        if (rs1 == '0) begin
            rs1Val = '0;
        end else if (wbActive && (wbRd == rs1)) begin
            rs1Val = wbData;
        end else begin
            rs1Val = regs[rs1];
        end

        if (rs2 == '0) begin
            rs2Val = '0;
        end else if (wbActive && (wbRd == rs2)) begin
            rs2Val = wbData;
        end else begin
            rs2Val = regs[rs2];
        end
    end

endmodule

//--- rtl/issueStage.sv
`include "decode_settings.svh"

module issueStage (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   instReq,
    output logic                   instAck,
    input  logic [`XLEN-1:0]       instPc,
    input  logic                   instPd,
    input  logic [`REG_NAME_W-1:0] rd,
    input  decodePkg::opT          op,
    input  logic [`XLEN-1:0]       imm,
    input  logic [`XLEN-1:0]       rs1Val,
    input  logic [`XLEN-1:0]       rs2Val,
    output logic                   issueReq,
    input  logic                   issueAck,
    output decodePkg::opT          issueOp,
    output logic [`XLEN-1:0]       issuePc,
    output logic [`XLEN-1:0]       issueImm,
    output logic [`XLEN-1:0]       issueRs1Val,
    output logic [`XLEN-1:0]       issueRs2Val,
    output logic [`REG_NAME_W-1:0] issueRd,
    output logic                   issuePd
);
    import decodePkg::*;

    issueStateT inState;
    issueStateT outState;
    logic       full;
    logic       capture;

    // Output register holds a record until the sink drops ack.
    assign full    = (outState != ST_IDLE);
    assign capture = (inState == ST_IDLE) && instReq && !full;

    assign instAck  = (inState == ST_ACTIVE);
    assign issueReq = (outState == ST_ACTIVE);

    // Input side handshake.
    always_ff @(posedge clk) begin
        if (rst) begin
            inState <= ST_IDLE;
        end else begin
            case (inState)
                ST_IDLE: begin
                    if (capture) begin
                        inState <= ST_ACTIVE;
                    end
                end
                ST_ACTIVE: begin
                    if (!instReq) begin
                        inState <= ST_IDLE;
                    end
                end
                default: inState <= ST_IDLE;
            endcase
        end
    end

    // Output side handshake.
    always_ff @(posedge clk) begin
        if (rst) begin
            outState <= ST_IDLE;
        end else begin
            case (outState)
                ST_IDLE: begin
                    if (capture) begin
                        outState <= ST_ACTIVE;
                    end
                end
                ST_ACTIVE: begin
                    if (issueAck) begin
                        outState <= ST_RELEASE;
                    end
                end
                ST_RELEASE: begin
                    if (!issueAck) begin
                        outState <= ST_IDLE;
                    end
                end
                default: outState <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            issueOp     <= NOP;
            issuePc     <= '0;
            issueImm    <= '0;
            issueRs1Val <= '0;
            issueRs2Val <= '0;
            issueRd     <= '0;
            issuePd     <= 1'b0;
        end else if (capture) begin
            issueOp     <= op;
            issuePc     <= instPc;
            issueImm    <= imm;
            issueRs1Val <= rs1Val;
            issueRs2Val <= rs2Val;
            issueRd     <= rd;
            issuePd     <= instPd;
        end
    end

endmodule

//--- rtl/decodeTop.sv
`include "decode_settings.svh"

module decodeTop (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   instReq,
    output logic                   instAck,
    input  logic [31:0]            inst,
    input  logic [`XLEN-1:0]       instPc,
    input  logic                   instPd,
    output logic                   issueReq,
    input  logic                   issueAck,
    output decodePkg::opT          issueOp,
    output logic [`XLEN-1:0]       issuePc,
    output logic [`XLEN-1:0]       issueImm,
    output logic [`XLEN-1:0]       issueRs1Val,
    output logic [`XLEN-1:0]       issueRs2Val,
    output logic [`REG_NAME_W-1:0] issueRd,
    output logic                   issuePd,
    input  logic                   wbEn,
    input  logic [`REG_NAME_W-1:0] wbRd,
    input  logic [`XLEN-1:0]       wbData
);
    import decodePkg::*;

    opT               decOp;
    logic [`XLEN-1:0] decImm;
    logic [`XLEN-1:0] rs1Val;
    logic [`XLEN-1:0] rs2Val;

    opDecoder i_opDecoder (
        .inst (inst),
        .op   (decOp)
    );

    immGenerator i_immGenerator (
        .inst (inst),
        .imm  (decImm)
    );

    // Operand read uses the rs1 and rs2 fields directly.
    regFile i_regFile (
        .clk    (clk),
        .rst    (rst),
        .rs1    (inst[19:15]),
        .rs2    (inst[24:20]),
        .rs1Val (rs1Val),
        .rs2Val (rs2Val),
        .wbEn   (wbEn),
        .wbRd   (wbRd),
        .wbData (wbData)
    );

    issueStage i_issueStage (
        .clk         (clk),
        .rst         (rst),
        .instReq     (instReq),
        .instAck     (instAck),
        .instPc      (instPc),
        .instPd      (instPd),
        .rd          (inst[11:7]),
        .op          (decOp),
        .imm         (decImm),
        .rs1Val      (rs1Val),
        .rs2Val      (rs2Val),
        .issueReq    (issueReq),
        .issueAck    (issueAck),
        .issueOp     (issueOp),
        .issuePc     (issuePc),
        .issueImm    (issueImm),
        .issueRs1Val (issueRs1Val),
        .issueRs2Val (issueRs2Val),
        .issueRd     (issueRd),
        .issuePd     (issuePd)
    );

endmodule

//--- testbench/clockGen.sv
module clockGen #(parameter realtime period = 10.0) (output logic clk);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever #(period / 2.0) clk = ~clk;
    end

endmodule

//--- testbench/decodeTb.sv
`include "decode_settings.svh"

module decodeTb;
    timeunit 1ns;
    timeprecision 1ps;
    import decodePkg::*;

    localparam int numInst = 400;
    localparam int resetCycles = 16;
    localparam int timeoutCycles = numInst * 20 + resetCycles;
    localparam int recW = 6 + 4 * `XLEN + `REG_NAME_W + 1;
    localparam integer seedInit = 32'hd77a29ad;

    logic clk, rst, instReq, instAck, instPd, issueReq, issueAck, issuePd, wbEn;
    logic [31:0] inst;
    logic [`XLEN-1:0] instPc, issuePc, issueImm, issueRs1Val, issueRs2Val, wbData;
    logic [`REG_NAME_W-1:0] issueRd, wbRd;
    opT issueOp;

    integer seedInst, seedAck, seedWb;
    int errors = 0;
    int protoErrors = 0;
    int issuedCount = 0;
    logic [`XLEN-1:0] shadow [`REG_COUNT];
    logic [recW-1:0] recQ [$];
    logic [recW-1:0] snapRec;
    logic [`REG_NAME_W-1:0] snapRs1 = '0;
    logic [31:0] wbRand;
    logic reqAtEdge = 1'b0, ackAtEdge = 1'b0;
    logic prevInstAck = 1'b0, prevIssueReq = 1'b0;

    // Expected operation for each funct3.
    opT brTab [8] = '{BEQ, BNE, NOP, NOP, BLT, BGE, BLTU, BGEU};
    opT ldTab [8] = '{LB, LH, LW, NOP, LBU, LHU, NOP, NOP};
    opT stTab [8] = '{SB, SH, SW, NOP, NOP, NOP, NOP, NOP};
    opT immTab [8] = '{ADDI, SLLI, SLTI, SLTIU, XORI, SRLI, ORI, ANDI};
    opT regTab [8] = '{ADD, SLL, SLT, SLTU, XOR, SRL, OR, AND};
    opcodeT opcList [9] = '{OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR, OPC_BRANCH,
                            OPC_LOAD, OPC_STORE, OPC_OPIMM, OPC_OP};

    clockGen i_clockGen (.clk(clk));
    decodeTop i_decodeTop (.*);

    function automatic opT expectOp(input logic [31:0] w);
        logic [2:0] f3;
        f3 = w[14:12];
        case (w[6:0])
            OPC_LUI:    return LUI;
            OPC_AUIPC:  return AUIPC;
            OPC_JAL:    return JAL;
            OPC_JALR:   return (f3 == 3'd0) ? JALR : NOP;
            OPC_BRANCH: return brTab[f3];
            OPC_LOAD:   return ldTab[f3];
            OPC_STORE:  return stTab[f3];
            // Bit 30 turns SRLI into SRAI and has no SLLI variant.
            OPC_OPIMM:  return (w[30] && f3 == 3'd1) ? NOP : (w[30] && f3 == 3'd5) ? SRAI
                               : immTab[f3];
            OPC_OP:     return !w[30] ? regTab[f3] : (f3 == 3'd0) ? SUB
                               : (f3 == 3'd5) ? SRA : NOP;
            default:    return NOP;
        endcase
    endfunction

    function automatic logic [`XLEN-1:0] expectImm(input logic [31:0] w);
        logic [20:0] jImm;
        logic [12:0] bImm;
        logic [11:0] sImm;
        jImm = {w[31], w[19:12], w[20], w[30:21], 1'b0};
        bImm = {w[31], w[7], w[30:25], w[11:8], 1'b0};
        sImm = {w[31:25], w[11:7]};
        case (w[6:0])
            OPC_LUI, OPC_AUIPC:            return {w[31:12], 12'h000};
            OPC_JAL:                       return {{(`XLEN-21){jImm[20]}}, jImm};
            OPC_BRANCH:                    return {{(`XLEN-13){bImm[12]}}, bImm};
            OPC_JALR, OPC_LOAD, OPC_OPIMM: return {{(`XLEN-12){w[31]}}, w[31:20]};
            OPC_STORE:                     return {{(`XLEN-12){sImm[11]}}, sImm};
            default:                       return '0;
        endcase
    endfunction

    // Operand as seen on a clock edge including a write on that edge.
    function automatic logic [`XLEN-1:0] readReg(input logic [`REG_NAME_W-1:0] idx);
        return (idx == '0) ? '0 : (wbEn && wbRd == idx) ? wbData : shadow[idx];
    endfunction

    task automatic checkEq(input logic [recW-1:0] got, input logic [recW-1:0] exp,
                           input string what);
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t: %s, got %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic reportViolation(input string what);
        protoErrors++;
        $display("ERROR at %0t: handshake violation, %s", $time, what);
    endtask

    task automatic driveInstructions();
        logic [31:0] r;
        for (int n = 0; n < numInst; n++) begin
            r = $random(seedInst);
            repeat (r[31:16] % 5) @(negedge clk);
            inst = $random(seedInst);
            // One word in eight keeps its random opcode.
            if (r[2:0] != 3'd0) begin
                inst[6:0] = opcList[r[15:8] % 9];
            end
            instPc  = $random(seedInst);
            instPd  = r[3];
            instReq = 1'b1;
            @(negedge clk iff instAck);
            instReq = 1'b0;
            @(negedge clk iff !instAck);
        end
    endtask

    task automatic sinkRecords();
        for (int n = 0; n < numInst; n++) begin
            @(negedge clk iff issueReq);
            repeat ($unsigned($random(seedAck)) % 5) @(negedge clk);
            issueAck = 1'b1;
            @(negedge clk iff !issueReq);
            issueAck = 1'b0;
        end
    endtask

    // Sample the bus and advance the shadow registers.
    always @(posedge clk) begin
        reqAtEdge = instReq;
        ackAtEdge = issueAck;
        snapRs1   = inst[19:15];
        snapRec   = {expectOp(inst), instPc, expectImm(inst), readReg(inst[19:15]),
                     readReg(inst[24:20]), inst[11:7], instPd};
        if (rst) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                shadow[i] = '0;
            end
        end else if (wbEn && wbRd != '0) begin
            shadow[wbRd] = wbData;
        end
    end

    always @(negedge clk) begin
        if (!rst) begin
            if (instAck && !prevInstAck) begin
                if (!reqAtEdge) begin
                    reportViolation("instAck rose without instReq");
                end
                recQ.push_back(snapRec);
            end
            if (!instAck && prevInstAck && reqAtEdge) begin
                reportViolation("instAck fell while instReq was still high");
            end
            if (issueReq && !prevIssueReq) begin
                if (ackAtEdge) begin
                    reportViolation("issueReq rose again before issueAck fell");
                end
                if (recQ.size() == 0) begin
                    errors++;
                    $display("ERROR at %0t: a record was issued that was never captured", $time);
                end else begin
                    checkEq({issueOp, issuePc, issueImm, issueRs1Val, issueRs2Val, issueRd,
                             issuePd}, recQ.pop_front(), "issue record");
                end
                issuedCount++;
            end
            if (!issueReq && prevIssueReq && !ackAtEdge) begin
                reportViolation("issueReq fell before issueAck rose");
            end
        end
        prevInstAck  = instAck;
        prevIssueReq = issueReq;
        // Writebacks start after the first issue and sometimes target rs1 on the bus.
        if (issuedCount > 0) begin
            wbRand = $random(seedWb);
            wbEn   = wbRand[0];
            wbRd   = (wbRand[2:1] == 2'd0) ? snapRs1 : wbRand[7:3];
            wbData = $random(seedWb);
        end
    end

    initial begin
        seedInst = seedInit;
        seedAck  = seedInit + 1;
        seedWb   = seedInit + 2;
        rst      = 1'b1;
        instReq  = 1'b0;
        inst     = '0;
        instPc   = '0;
        instPd   = 1'b0;
        issueAck = 1'b0;
        wbEn     = 1'b0;
        wbRd     = '0;
        wbData   = '0;
        repeat (resetCycles) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        checkEq(instAck, 1'b0, "instAck after reset");
        checkEq(issueReq, 1'b0, "issueReq after reset");
        fork
            driveInstructions();
            sinkRecords();
        join
        repeat (4) @(negedge clk);
        checkEq(issuedCount, numInst, "issued record count");
        checkEq(recQ.size(), 0, "records captured but never issued");
        $display("Errors: %0d value, %0d handshake", errors, protoErrors);
        if (errors == 0 && protoErrors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    // Watchdog.
    initial begin
        repeat (timeoutCycles) @(posedge clk);
        $display("ERROR: timeout, the run did not finish within %0d cycles", timeoutCycles);
        $display("Errors: %0d value, %0d handshake", errors, protoErrors);
        $display("Result: FAILED");
        $finish;
    end

endmodule

//--- src.f
+incdir+include
rtl/decodePkg.sv
rtl/opDecoder.sv
rtl/immGenerator.sv
rtl/regFile.sv
rtl/issueStage.sv
rtl/decodeTop.sv
testbench/clockGen.sv
testbench/decodeTb.sv

//--- Bender.yml
package:
  name: decode_stage

sources:
  - include_dirs:
      - include
    files:
      - rtl/decodePkg.sv
      - rtl/opDecoder.sv
      - rtl/immGenerator.sv
      - rtl/regFile.sv
      - rtl/issueStage.sv
      - rtl/decodeTop.sv
  - target: test
    include_dirs:
      - include
    files:
      - testbench/clockGen.sv
      - testbench/decodeTb.sv
